/* sata_phy.f */
+incdir+source
source/sata_phy_pkg.sv
source/sata_oob_timer.sv
source/sata_prim_detect.sv
source/sata_link_fsm.sv
source/sata_tx_framer.sv
source/sata_linkup_delay.sv
source/sata_phy_core.sv
tb/sata_phy_chk.sv
tb/sata_phy_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the SATA PHY testbench with Verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sata_phy.f --top-module sata_phy_tb \
    -o sata_phy_sim && ./obj_dir/sata_phy_sim > sim.log 2>&1
grep -q "^=== PASS ===$" sim.log && echo "simulation passed" || {
    echo "simulation failed, see sim.log"
    exit 1
}

/* tb/sata_phy_tb.sv */
//----------------------------------------
// SATA PHY link core testbench
// OOB partner model and directed tests for
// bring-up, retry, framing and link loss
//----------------------------------------

`include "sata_phy_config.svh"

module sata_phy_tb
    import sata_phy_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int TIMEOUT      = `SATA_TIMEOUT_CYCLES;
    localparam int LINKUP_DELAY = `SATA_LINKUP_DELAY;
    localparam int ALIGN_PERIOD = 1 << `SATA_ALIGN_PERIOD_LOG2;
    localparam int DATA_CYCLES  = 600;
    // reset, two retry windows, bring-up, data, link loss
    localparam int RUN_CYCLES   = 3 + 2 * (TIMEOUT + 20) + LINKUP_DELAY + 80 + DATA_CYCLES + 30;

    logic   tx_reset;               // clock
    logic   tx_clk;                 // reset
    logic   phy_locked, oob_ready, rx_cominit, rx_comwake, rx_oobfinish;
    logic   signal_detect, tx_datak, tx_ready, oob_cominit, oob_comwake;
    logic   oob_finish, phy_tx_datak, linkup;
    sync_t  sync_status;
    dword_t rx_data, tx_data, phy_tx_data;
    datak_t rx_datak;

    logic   answer_en;              // OOB partner answers requests
    int     seed;
    int     errors;
    int     tests_run;
    int     tests_failed;

    sata_phy_core i_dut (
        .tx_reset      (tx_reset),
        .tx_clk        (tx_clk),
        .phy_locked    (phy_locked),
        .oob_ready     (oob_ready),
        .rx_cominit    (rx_cominit),
        .rx_comwake    (rx_comwake),
        .rx_oobfinish  (rx_oobfinish),
        .signal_detect (signal_detect),
        .sync_status   (sync_status),
        .rx_data       (rx_data),
        .rx_datak      (rx_datak),
        .tx_data       (tx_data),
        .tx_datak      (tx_datak),
        .tx_ready      (tx_ready),
        .oob_cominit   (oob_cominit),
        .oob_comwake   (oob_comwake),
        .oob_finish    (oob_finish),
        .phy_tx_data   (phy_tx_data),
        .phy_tx_datak  (phy_tx_datak),
        .linkup        (linkup)
    );

    bind sata_phy_core sata_phy_chk i_chk (
        .tx_reset    (tx_reset),
        .tx_clk      (tx_clk),
        .oob_cominit (oob_cominit),
        .oob_comwake (oob_comwake),
        .tx_ready    (tx_ready),
        .link_ready  (link_ready),
        .linkup      (linkup)
    );

    initial begin
        tx_reset = 1'b0;
        forever #(CLK_PERIOD / 2) tx_reset = ~tx_reset;
    end

    //----------------------------------------
    // helpers
    //----------------------------------------
    task automatic tick();          // next drive point
        @(posedge tx_reset);
        #(DRIVE_DELAY);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic logic probe(input string name);
        case (name)
            "oob_cominit": return oob_cominit;
            "oob_comwake": return oob_comwake;
            "oob_finish":  return oob_finish;
            "linkup":      return linkup;
            "linkup_low":  return !linkup;
            default:       return 1'bx;
        endcase
    endfunction

    // poll at falling edges, give up after limit cycles
    task automatic wait_for(input string name, input int limit);
        int n;
        n = 0;
        while (probe(name) !== 1'b1 && n < limit) begin
            @(negedge tx_reset);
            n++;
        end
        if (probe(name) !== 1'b1) begin
            $display("ERROR t=%0t %s not seen within %0d cycles", $time, name, limit);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_err);
        tests_run++;
        if (errors == start_err) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d failing checks", name, errors - start_err);
        end
    endtask

    //----------------------------------------
    // OOB partner, answers at drive points
    //----------------------------------------
    initial begin
        logic answer;               // taken when the request shows up
        oob_ready    = 1'b1;        // coder always free
        rx_cominit   = 1'b0;
        rx_comwake   = 1'b0;
        rx_oobfinish = 1'b0;
        forever begin
            @(negedge tx_reset);
            if (oob_cominit === 1'b1) begin
                answer = answer_en;
                tick();
                rx_oobfinish = 1'b0;            // new OOB sequence
                if (answer) begin
                    tick();
                    tick();
                    rx_cominit = 1'b1;
                    tick();
                    rx_cominit = 1'b0;
                end
            end else if (oob_comwake === 1'b1 && answer_en) begin
                repeat (2) tick();
                rx_comwake = 1'b1;
                tick();
                rx_comwake   = 1'b0;
                rx_oobfinish = 1'b1;            // OOB done, held
            end
        end
    end

    //----------------------------------------
    // directed tests
    //----------------------------------------
    task automatic test_reset_values();
        int start_err;
        start_err = errors;
        repeat (2) @(posedge tx_reset);
        @(negedge tx_reset);        // still in reset
        check_eq("linkup", linkup, 0);
        check_eq("oob_cominit", oob_cominit, 0);
        check_eq("oob_comwake", oob_comwake, 0);
        check_eq("tx_ready", tx_ready, 1);
        check_eq("phy_tx_data", phy_tx_data, 0);
        tick();
        tx_clk = 1'b0;
        @(negedge tx_reset);
        check_eq("linkup", linkup, 0);
        check_eq("oob_cominit", oob_cominit, 0);   // phy not locked yet
        check_eq("tx_ready", tx_ready, 1);
        report_test("reset_values", start_err);
    endtask

    task automatic test_timeout_retry();
        int start_err;
        int n;
        start_err = errors;
        tick();
        phy_locked = 1'b1;
        wait_for("oob_cominit", 10);
        @(negedge tx_reset);
        n = 1;
        while (oob_cominit !== 1'b1 && n < TIMEOUT + 10) begin
            check_eq("linkup", linkup, 0);
            @(negedge tx_reset);
            n++;
        end
        if (oob_cominit !== 1'b1) begin
            $display("ERROR t=%0t no COMRESET retry after %0d cycles", $time, n);
            errors++;
        end
        report_test("timeout_retry", start_err);
    endtask

    task automatic test_bring_up();
        int start_err;
        start_err = errors;
        tick();
        answer_en = 1'b1;
        wait_for("oob_cominit", TIMEOUT + 20);     // retry pulse went unanswered
        wait_for("oob_comwake", 20);
        wait_for("oob_finish", 20);
        repeat (2) @(negedge tx_reset);
        repeat (5) begin            // dial until ALIGN comes back
            check_eq("phy_tx_data", phy_tx_data, `SATA_DIAL_DATA);
            check_eq("phy_tx_datak", phy_tx_datak, 0);
            check_eq("linkup", linkup, 0);
            @(negedge tx_reset);
        end
        tick();
        rx_data  = `SATA_ALIGN_PRIM;
        rx_datak = 4'b0001;
        repeat (4) @(negedge tx_reset);
        check_eq("phy_tx_data", phy_tx_data, `SATA_ALIGN_PRIM);
        check_eq("phy_tx_datak", phy_tx_datak, 1);
        tick();
        rx_data = `SATA_SYNC_PRIM;
        wait_for("linkup", LINKUP_DELAY + 10);
        tick();
        rx_data  = '0;
        rx_datak = '0;
        report_test("bring_up", start_err);
    endtask

    task automatic test_user_data();
        int     start_err;
        int     runs;
        int     run_len;
        int     rnd;
        logic   have_prev;
        dword_t exp_data;
        logic   exp_k;
        start_err = errors;
        runs      = 0;
        run_len   = 0;
        have_prev = 1'b0;
        check_eq("linkup", linkup, 1);
        repeat (DATA_CYCLES) begin
            tick();
            tx_data  = $random(seed);
            rnd      = $random(seed);
            tx_datak = rnd[0];
            @(negedge tx_reset);
            if (have_prev) begin    // word taken at the last edge
                check_eq("phy_tx_data", phy_tx_data, exp_data);
                check_eq("phy_tx_datak", phy_tx_datak, exp_k);
            end
            exp_data  = tx_ready ? tx_data : `SATA_ALIGN_PRIM;
            exp_k     = tx_ready ? tx_datak : 1'b1;
            have_prev = 1'b1;
            if (!tx_ready) begin
                run_len++;
                if (run_len == 1) runs++;
            end else begin
                if (run_len != 0) check_eq("tx_ready low run", run_len, 2);
                run_len = 0;
            end
        end
        if (run_len > 2) check_eq("tx_ready low run", run_len, 2);
        // one pair per period, window may catch one more
        if (runs < DATA_CYCLES / ALIGN_PERIOD || runs > DATA_CYCLES / ALIGN_PERIOD + 1) begin
            $display("ERROR t=%0t %0d ALIGN pairs in %0d cycles", $time, runs, DATA_CYCLES);
            errors++;
        end
        tick();
        tx_data  = '0;
        tx_datak = 1'b0;
        @(negedge tx_reset);        // last offered word
        check_eq("phy_tx_data", phy_tx_data, exp_data);
        check_eq("phy_tx_datak", phy_tx_datak, exp_k);
        report_test("user_data", start_err);
    endtask

    task automatic test_link_loss();
        int start_err;
        start_err = errors;
        tick();
        answer_en     = 1'b0;       // keep the retry in wait_cominit
        signal_detect = 1'b0;
        wait_for("linkup_low", 5);
        check_eq("phy_tx_data", phy_tx_data, `SATA_ALIGN_PRIM);
        check_eq("phy_tx_datak", phy_tx_datak, 1);
        wait_for("oob_cominit", 10);
        report_test("link_loss", start_err);
    endtask

    //----------------------------------------
    // main sequence and watchdog
    //----------------------------------------
    initial begin
        seed          = 59712;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        answer_en     = 1'b0;
        tx_clk        = 1'b1;       // reset held from time zero
        phy_locked    = 1'b0;
        signal_detect = 1'b1;
        sync_status   = 4'hF;
        rx_data       = '0;
        rx_datak      = '0;
        tx_data       = '0;
        tx_datak      = 1'b0;
        test_reset_values();
        test_timeout_retry();
        test_bring_up();
        test_user_data();
        test_link_loss();
        $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, errors, i_dut.i_chk.fail_count);
        if (errors == 0 && i_dut.i_chk.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(2 * RUN_CYCLES * CLK_PERIOD);
        $display("ERROR t=%0t watchdog expired, tests did not finish", $time);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* tb/sata_phy_chk.sv */
//----------------------------------------
// SATA PHY core checker
// bound assertions on OOB requests, ALIGN
// insertion and the linkup indication
//----------------------------------------

`include "sata_phy_config.svh"

module sata_phy_chk (
    input logic tx_reset,           // clock
    input logic tx_clk,             // async reset, active high
    input logic oob_cominit,
    input logic oob_comwake,
    input logic tx_ready,
    input logic link_ready,
    input logic linkup
);

    int fail_count;                 // assertion failures so far

    initial fail_count = 0;

    // only one OOB request at a time
    a_oob_exclusive: assert property (@(posedge tx_reset) disable iff (tx_clk)
        !(oob_cominit && oob_comwake))
    else begin
        $error("oob_cominit and oob_comwake high in the same cycle");
        fail_count = fail_count + 1;
    end

    // ALIGN pair, never a third low cycle
    a_align_pair: assert property (@(posedge tx_reset) disable iff (tx_clk)
        (!tx_ready && !$past(tx_ready)) |=> tx_ready)
    else begin
        $error("tx_ready low for more than two cycles");
        fail_count = fail_count + 1;
    end

    // linkup only once link ready has held for the settle period
    a_linkup_ready: assert property (@(posedge tx_reset) disable iff (tx_clk)
        linkup |-> $past(link_ready) && $past(link_ready, `SATA_LINKUP_DELAY))
    else begin
        $error("linkup high without link_ready held for the settle period");
        fail_count = fail_count + 1;
    end

endmodule

/* source/sata_phy_core.sv */
//----------------------------------------
// SATA PHY link core
// bring-up FSM, primitive detector, timer,
// transmit framer and linkup delay
//----------------------------------------

module sata_phy_core
    import sata_phy_pkg::*;
(
    input  logic   tx_reset,        // clock
    input  logic   tx_clk,          // async reset, active high

    // transceiver and OOB status
    input  logic   phy_locked,
    input  logic   oob_ready,
    input  logic   rx_cominit,
    input  logic   rx_comwake,
    input  logic   rx_oobfinish,
    input  logic   signal_detect,
    input  sync_t  sync_status,

    // received dwords, detector only
    input  dword_t rx_data,
    input  datak_t rx_datak,

    // user transmit side
    input  dword_t tx_data,
    input  logic   tx_datak,
    output logic   tx_ready,

    // OOB coder requests
    output logic   oob_cominit,
    output logic   oob_comwake,
    output logic   oob_finish,

    // transceiver transmit side
    output dword_t phy_tx_data,
    output logic   phy_tx_datak,

    output logic   linkup
);

    //----------------------------------------
    // internal nets
    //----------------------------------------
    logic align_seen;
    logic sync_seen;
    logic link_ok;
    logic timer_run;
    logic timeout;
    logic tx_dial;
    logic link_ready;

    sata_prim_detect i_detect (
        .tx_reset      (tx_reset),
        .tx_clk        (tx_clk),
        .rx_data       (rx_data),
        .rx_datak      (rx_datak),
        .sync_status   (sync_status),
        .signal_detect (signal_detect),
        .align_seen    (align_seen),
        .sync_seen     (sync_seen),
        .link_ok       (link_ok)
    );

    sata_oob_timer i_timer (
        .tx_reset  (tx_reset),
        .tx_clk    (tx_clk),
        .timer_run (timer_run),
        .timeout   (timeout)
    );

    sata_link_fsm i_fsm (
        .tx_reset     (tx_reset),
        .tx_clk       (tx_clk),
        .phy_locked   (phy_locked),
        .oob_ready    (oob_ready),
        .rx_cominit   (rx_cominit),
        .rx_comwake   (rx_comwake),
        .rx_oobfinish (rx_oobfinish),
        .align_seen   (align_seen),
        .sync_seen    (sync_seen),
        .link_ok      (link_ok),
        .timeout      (timeout),
        .oob_cominit  (oob_cominit),
        .oob_comwake  (oob_comwake),
        .oob_finish   (oob_finish),
        .tx_dial      (tx_dial),
        .link_ready   (link_ready),
        .timer_run    (timer_run)
    );

    sata_tx_framer i_framer (
        .tx_reset     (tx_reset),
        .tx_clk       (tx_clk),
        .link_ready   (link_ready),
        .tx_dial      (tx_dial),
        .tx_data      (tx_data),
        .tx_datak     (tx_datak),
        .phy_tx_data  (phy_tx_data),
        .phy_tx_datak (phy_tx_datak),
        .tx_ready     (tx_ready)
    );

    sata_linkup_delay i_linkup (
        .tx_reset   (tx_reset),
        .tx_clk     (tx_clk),
        .link_ready (link_ready),
        .linkup     (linkup)
    );

endmodule

/* source/sata_linkup_delay.sv */
//----------------------------------------
// SATA linkup delay
// raises linkup once link ready has held
// for the settle period
//----------------------------------------

`include "sata_phy_config.svh"

module sata_linkup_delay (
    input  logic tx_reset,          // clock
    input  logic tx_clk,            // async reset, active high
    input  logic link_ready,
    output logic linkup
);

    localparam int unsigned CW = $clog2(`SATA_LINKUP_DELAY);
    localparam logic [CW-1:0] CNT_MAX = CW'(`SATA_LINKUP_DELAY - 1);

    logic [CW-1:0] cnt;

    // saturating settle counter
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            cnt <= '0;
        end else if (!link_ready) begin
            cnt <= '0;
        end else if (cnt != CNT_MAX) begin
            cnt <= cnt + 1'b1;
        end
    end

    // drops one cycle after link_ready does
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            linkup <= 1'b0;
        end else begin
            linkup <= link_ready && (cnt == CNT_MAX);
        end
    end

endmodule

/* source/sata_tx_framer.sv */
//----------------------------------------
// SATA transmit framer
// dial word during bring-up, user dwords
// with periodic ALIGN pairs when ready
//----------------------------------------

`include "sata_phy_config.svh"

module sata_tx_framer
    import sata_phy_pkg::*;
(
    input  logic   tx_reset,        // clock
    input  logic   tx_clk,          // async reset, active high
    input  logic   link_ready,
    input  logic   tx_dial,
    input  dword_t tx_data,         // user dword
    input  logic   tx_datak,
    output dword_t phy_tx_data,
    output logic   phy_tx_datak,
    output logic   tx_ready         // low while an ALIGN pair goes out
);

    localparam int unsigned PW = `SATA_ALIGN_PERIOD_LOG2;

    logic [PW-1:0] period_cnt;
    logic          align_flag;

    //----------------------------------------
    // ALIGN period
    //----------------------------------------
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            period_cnt <= '0;
        end else if (link_ready) begin
            period_cnt <= period_cnt + 1'b1;    // wraps every 2**PW dwords
        end else begin
            period_cnt <= '0;
        end
    end

    // two slots per period, counts 0 and 1
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            align_flag <= 1'b0;
        end else begin
            align_flag <= link_ready && (period_cnt <= PW'(1));
        end
    end

    assign tx_ready = !align_flag;

    //----------------------------------------
    // output dword select
    //----------------------------------------
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            phy_tx_data  <= '0;
            phy_tx_datak <= 1'b0;
        end else if (tx_dial) begin
            phy_tx_data  <= `SATA_DIAL_DATA;    // plain data, no K symbol
            phy_tx_datak <= `SATA_DWORD_IS_DATA;
        end else if (link_ready && !align_flag) begin
            phy_tx_data  <= tx_data;            // user slot
            phy_tx_datak <= tx_datak;
        end else begin
            phy_tx_data  <= `SATA_ALIGN_PRIM;   // idle fill and inserted pairs
            phy_tx_datak <= `SATA_DWORD_IS_PRIM;
        end
    end

endmodule

/* source/sata_link_fsm.sv */
//----------------------------------------
// SATA link bring-up FSM
// COMRESET / COMWAKE handshake, dial and
// ALIGN phases, link ready supervision
//----------------------------------------

module sata_link_fsm
    import sata_phy_pkg::*;
(
    input  logic tx_reset,          // clock
    input  logic tx_clk,            // async reset, active high
    input  logic phy_locked,        // transceiver locked to reference
    input  logic oob_ready,         // OOB coder free
    input  logic rx_cominit,        // pulse from OOB decoder
    input  logic rx_comwake,        // pulse from OOB decoder
    input  logic rx_oobfinish,
    input  logic align_seen,
    input  logic sync_seen,
    input  logic link_ok,
    input  logic timeout,
    output logic oob_cominit,       // one cycle request
    output logic oob_comwake,       // one cycle request
    output logic oob_finish,
    output logic tx_dial,
    output logic link_ready,
    output logic timer_run
);

    link_state_t state;
    link_state_t state_next;

    //----------------------------------------
    // next state
    //----------------------------------------
    always_comb begin
        state_next = state;                     // hold by default
        case (state)
            st_idle: begin
                if (phy_locked) begin
                    state_next = st_send_comreset;
                end
            end
            st_send_comreset: begin
                state_next = st_suspend_comreset;
            end
            st_suspend_comreset: begin
                if (oob_ready) begin
                    state_next = st_wait_cominit;   // COMRESET burst sent
                end
            end
            st_wait_cominit: begin
                if (rx_cominit) begin
                    state_next = st_send_comwake;
                end else if (timeout) begin
                    state_next = st_idle;           // retry from the start
                end
            end
            st_send_comwake: begin
                state_next = st_suspend_comwake;
            end
            st_suspend_comwake: begin
                if (oob_ready) begin
                    state_next = st_wait_comwake;
                end
            end
            st_wait_comwake: begin
                if (rx_comwake) begin
                    state_next = st_wait_oobfinish;
                end else if (timeout) begin
                    state_next = st_idle;
                end
            end
            st_wait_oobfinish: begin
                if (rx_oobfinish) begin
                    state_next = st_send_dial;
                end else if (timeout) begin
                    state_next = st_idle;
                end
            end
            st_send_dial: begin
                if (align_seen) begin
                    state_next = st_send_align;     // device locked to us
                end else if (timeout) begin
                    state_next = st_idle;
                end
            end
            st_send_align: begin
                if (sync_seen) begin
                    state_next = st_link_ready;
                end else if (timeout) begin
                    state_next = st_idle;
                end
            end
            st_link_ready: begin
                if (!link_ok) begin
                    state_next = st_idle;           // signal or sync lost
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    //----------------------------------------
    // state register
    //----------------------------------------
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    //----------------------------------------
    // output decode
    //----------------------------------------
    assign oob_cominit = (state == st_send_comreset);
    assign oob_comwake = (state == st_send_comwake);

    // OOB done from here on
    assign oob_finish = (state == st_wait_oobfinish) || (state == st_send_dial)
                     || (state == st_send_align) || (state == st_link_ready);

    assign tx_dial    = (state == st_send_dial);   // ALIGN goes out in send_align
    assign link_ready = (state == st_link_ready);

    // states guarded by the timeout timer
    assign timer_run = (state == st_wait_cominit) || (state == st_wait_comwake)
                    || (state == st_wait_oobfinish) || (state == st_send_dial)
                    || (state == st_send_align);

endmodule

/* source/sata_prim_detect.sv */
//----------------------------------------
// SATA received primitive detector
// registers rx dword and status, flags
// ALIGN, SYNC and link health
//----------------------------------------

`include "sata_phy_config.svh"

module sata_prim_detect
    import sata_phy_pkg::*;
(
    input  logic   tx_reset,        // clock
    input  logic   tx_clk,          // async reset, active high
    input  dword_t rx_data,
    input  datak_t rx_datak,
    input  sync_t  sync_status,
    input  logic   signal_detect,
    output logic   align_seen,
    output logic   sync_seen,
    output logic   link_ok
);

    // primitive sits in byte 0 only
    localparam datak_t PRIM_K = {3'b000, `SATA_DWORD_IS_PRIM};

    dword_t rx_data_q;
    datak_t rx_datak_q;
    sync_t  sync_q;
    logic   sigdet_q;
    logic   all_sync;

    //----------------------------------------
    // input stage
    //----------------------------------------
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            rx_data_q  <= '0;
            rx_datak_q <= '0;
            sync_q     <= '0;
            sigdet_q   <= 1'b0;
        end else begin
            rx_data_q  <= rx_data;
            rx_datak_q <= rx_datak;
            sync_q     <= sync_status;
            sigdet_q   <= signal_detect;
        end
    end

    //----------------------------------------
    // primitive compare
    //----------------------------------------
    assign all_sync = &sync_q;                  // every byte lane in sync

    // ALIGN only counts with the lanes in sync
    assign align_seen = (rx_data_q == `SATA_ALIGN_PRIM) && (rx_datak_q == PRIM_K) && all_sync;
    assign sync_seen  = (rx_data_q == `SATA_SYNC_PRIM) && (rx_datak_q == PRIM_K);

    // carrier present and symbol sync held
    assign link_ok = sigdet_q && all_sync;

endmodule

/* source/sata_oob_timer.sv */
//----------------------------------------
// SATA OOB timeout timer
// counts cycles spent in wait states and
// flags a timeout at the configured limit
//----------------------------------------

`include "sata_phy_config.svh"

module sata_oob_timer (
    input  logic tx_reset,          // clock
    input  logic tx_clk,            // async reset, active high
    input  logic timer_run,         // high in every wait state
    output logic timeout
);

    localparam int unsigned TW = `SATA_TIMEOUT_WIDTH;
    localparam logic [TW-1:0] LIMIT = TW'(`SATA_TIMEOUT_CYCLES);

    logic [TW-1:0] cnt;

    //----------------------------------------
    // cycle counter
    //----------------------------------------
    // keeps counting across back-to-back wait states,
    // so the limit covers the whole run of them
    always_ff @(posedge tx_reset or posedge tx_clk) begin
        if (tx_clk) begin
            cnt <= '0;
        end else if (!timer_run) begin
            cnt <= '0;                          // left the wait states
        end else if (cnt != LIMIT) begin
            cnt <= cnt + 1'b1;
        end                                     // else hold at the limit
    end

    // limit reached, fsm drops to idle on the next edge
    assign timeout = (cnt == LIMIT);

endmodule

/* source/sata_phy_pkg.sv */
//----------------------------------------
// SATA PHY package
// dword and status types, link state enum
//----------------------------------------

package sata_phy_pkg;

    //----------------------------------------
    // data path types
    //----------------------------------------
    typedef logic [31:0] dword_t;   // tx or rx dword
    typedef logic [3:0]  datak_t;   // control symbol flag per rx byte
    typedef logic [3:0]  sync_t;    // per byte symbol sync

    //----------------------------------------
    // link bring-up states
    //----------------------------------------
    typedef enum logic [3:0] {
        st_idle,                    // waiting for phy lock
        st_send_comreset,           // COMRESET request pulse
        st_suspend_comreset,        // until OOB coder is free
        st_wait_cominit,            // device answer
        st_send_comwake,            // COMWAKE request pulse
        st_suspend_comwake,
        st_wait_comwake,
        st_wait_oobfinish,          // end of OOB signalling
        st_send_dial,               // dial until ALIGN comes back
        st_send_align,              // ALIGN until SYNC comes back
        st_link_ready
    } link_state_t;

endpackage

/* source/sata_phy_config.svh */
//----------------------------------------
// SATA PHY configuration
// primitive codes, bring-up timing and
// framing constants for the link core
//----------------------------------------

`ifndef SATA_PHY_CONFIG_SVH
`define SATA_PHY_CONFIG_SVH

//----------------------------------------
// primitive and filler dwords
//----------------------------------------
`define SATA_ALIGN_PRIM         32'h7B4A_4ABC   // K28.5 D10.2 D10.2 D27.3
`define SATA_SYNC_PRIM          32'hB5B5_957C   // K28.3 D21.4 D21.5 D21.5
`define SATA_DIAL_DATA          32'h4A4A_4A4A   // D10.2 x4, sent before ALIGN lock

// datak flag of a transmitted dword
`define SATA_DWORD_IS_PRIM      1'b1
`define SATA_DWORD_IS_DATA      1'b0

//----------------------------------------
// bring-up timing
//----------------------------------------
// wait state limit in clock cycles
// short value for simulation, ~132000 on hardware (880 us at 150 MHz)
`define SATA_TIMEOUT_CYCLES     200
`define SATA_TIMEOUT_WIDTH      8               // must hold SATA_TIMEOUT_CYCLES, 18 on hardware

//----------------------------------------
// framing
//----------------------------------------
`define SATA_ALIGN_PERIOD_LOG2  8               // one ALIGN pair per 256 dwords

// settle time between link ready and linkup
`define SATA_LINKUP_DELAY       32

`endif
